// ==== lcd_top.f ====
src/lcd_pkg.sv
src/lcd_ctrl_if.sv
src/lcd_registers.sv
src/dot_timer.sv
src/mode_control.sv
src/video_ram.sv
src/line_buffer.sv
src/bg_renderer.sv
src/lcd_top.sv
tests/lcd_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_top

sources:
  - src/lcd_pkg.sv
  - src/lcd_ctrl_if.sv
  - src/lcd_registers.sv
  - src/dot_timer.sv
  - src/mode_control.sv
  - src/video_ram.sv
  - src/line_buffer.sv
  - src/bg_renderer.sv
  - src/lcd_top.sv
  - target: test
    files:
      - tests/lcd_tb.sv

// ==== tests/lcd_tb.sv ====
`timescale 1ns/1ps

module lcd_tb
	import lcd_pkg::*;
();

	localparam int DOT_DIVIDE = 4;
	localparam int FRAME_CLOCKS = 70224 * DOT_DIVIDE;
	localparam int VRAM_BYTES = 8192;
	// Three frames of raster, VRAM fill and readback, and register setup
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CLOCKS + 2 * VRAM_BYTES + 5000;
	localparam logic [31:0] RAND_SEED = 32'h8187_fe32;
	// Addresses outside VRAM and the register set
	localparam logic [15:0] UNMAPPED [10] = '{
		16'hFF46, 16'hFF48, 16'hFF49, 16'hFF4A, 16'hFF4B,
		16'h0000, 16'h7FFF, 16'hA000, 16'hFF3F, 16'hFFFF
	};
	// STAT mode sequence over a visible line
	localparam int MODE_ORDER [3] = '{2, 3, 0};

	logic clock;
	logic reset;
	logic mem_enable;
	logic rd_n;
	logic wr_n;
	logic [15:0] addr;
	logic [7:0] wdata;
	logic int_vblank_ack;
	logic int_lcdc_ack;
	logic [7:0] rdata;
	logic int_vblank_req;
	logic int_lcdc_req;
	logic hsync;
	logic vsync;
	logic [7:0] line_count;
	logic [7:0] pixel_x;
	logic [1:0] pixel_data;
	logic pixel_we;

	// Testbench copy of VRAM
	logic [7:0] vram_model [0:VRAM_BYTES-1];
	// Settings in force for the pixel check
	logic [7:0] lcdc_val;
	logic [7:0] scx_val;
	logic [7:0] scy_val;
	logic [7:0] bgp_val;
	logic checking;
	int prev_line;
	int strobe_count;
	int total_strobes;
	int cycle_count;
	// Clocks since the current line began
	int line_clocks;
	logic dot_known;
	logic [1:0] expected_shade;

	lcd_top #(
		.DOT_DIVIDE(DOT_DIVIDE)
	) dut (
		.clock(clock),
		.reset(reset),
		.mem_enable(mem_enable),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.addr(addr),
		.wdata(wdata),
		.rdata(rdata),
		.int_vblank_ack(int_vblank_ack),
		.int_lcdc_ack(int_lcdc_ack),
		.int_vblank_req(int_vblank_req),
		.int_lcdc_req(int_lcdc_req),
		.hsync(hsync),
		.vsync(vsync),
		.line_count(line_count),
		.pixel_x(pixel_x),
		.pixel_data(pixel_data),
		.pixel_we(pixel_we)
	);

	always #2 clock = ~clock;

	////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////
	task automatic stop_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic fail_value(input string name, input int expected, input int actual);
		$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		stop_run();
	endtask

	task automatic fail_text(input string message);
		$display("%s", message);
		stop_run();
	endtask

	////////////////////////////////////////
	// CPU bus
	////////////////////////////////////////
	// Each task starts and ends at the drive point just after a rising edge
	task automatic step();
		@(posedge clock);
		#0.5;
	endtask

	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		mem_enable = 1'b1;
		wr_n = 1'b0;
		rd_n = 1'b1;
		addr = a;
		wdata = d;
		step();
		mem_enable = 1'b0;
		wr_n = 1'b1;
	endtask

	task automatic cpu_read(input logic [15:0] a, output logic [7:0] d);
		mem_enable = 1'b1;
		rd_n = 1'b0;
		wr_n = 1'b1;
		addr = a;
		step();
		mem_enable = 1'b0;
		rd_n = 1'b1;
		// Captured at the edge just passed
		d = rdata;
	endtask

	task automatic check_read(input logic [15:0] a, input logic [7:0] expected, input string name);
		logic [7:0] value;
		cpu_read(a, value);
		assert (value == expected) else fail_value(name, expected, value);
	endtask

	task automatic wait_line(input int line);
		while (line_count != 8'(line)) begin
			step();
		end
	endtask

	////////////////////////////////////////
	// Reference shade of one screen pixel
	////////////////////////////////////////
	function automatic logic [1:0] ref_shade(input int line, input int x,
		input logic [7:0] lcdc, input logic [7:0] scx, input logic [7:0] scy,
		input logic [7:0] bgp);
		int bg_x;
		int bg_y;
		int map_base;
		int tile_num;
		int tile_addr;
		int bit_pos;
		int index;
		logic [7:0] low_byte;
		logic [7:0] high_byte;
		index = 0;
		// Background off shows colour 0
		if (lcdc[0]) begin
			bg_x = (x + scx) % 256;
			bg_y = (line + scy) % 256;
			map_base = lcdc[3] ? 'h1C00 : 'h1800;
			tile_num = vram_model[map_base + (bg_y / 8) * 32 + bg_x / 8];
			if (lcdc[4]) begin
				tile_addr = tile_num * 16;
			end else begin
				// Tile numbers 128 to 255 count back from 0x1000
				tile_addr = 'h1000 + 16 * ((tile_num > 127) ? tile_num - 256 : tile_num);
			end
			tile_addr = tile_addr + 2 * (bg_y % 8);
			low_byte = vram_model[tile_addr];
			high_byte = vram_model[tile_addr + 1];
			bit_pos = 7 - (bg_x % 8);
			index = 2 * high_byte[bit_pos] + low_byte[bit_pos];
		end
		return 2'((bgp >> (2 * index)) & 3);
	endfunction

	////////////////////////////////////////
	// Pixel and raster comparison
	////////////////////////////////////////
	always @(negedge clock) begin
		if (!checking) begin
			strobe_count = 0;
			prev_line = line_count;
			line_clocks = 0;
			dot_known = 1'b0;
		end else begin
			assert (vsync == (line_count > 8'd144))
				else fail_value("vsync", line_count > 8'd144, vsync);
			if (line_count != prev_line) begin
				assert (line_count == (prev_line + 1) % 154)
					else fail_value("line_step", (prev_line + 1) % 154, line_count);
				// Every visible line streams a full row
				if (prev_line < 144) begin
					assert (strobe_count == 160)
						else fail_value("line_strobes", 160, strobe_count);
				end
				strobe_count = 0;
				prev_line = line_count;
				line_clocks = 0;
				dot_known = 1'b1;
			end
			// Dot position follows from the clocks since the line began
			if (dot_known) begin
				assert (hsync == (line_clocks / DOT_DIVIDE > 412))
					else fail_value("hsync", line_clocks / DOT_DIVIDE > 412, hsync);
			end
			line_clocks++;
			if (pixel_we) begin
				assert (pixel_x == strobe_count)
					else fail_value("pixel_x", strobe_count, pixel_x);
				expected_shade = ref_shade(line_count, pixel_x, lcdc_val, scx_val,
					scy_val, bgp_val);
				assert (pixel_data == expected_shade)
					else fail_value("pixel", expected_shade, pixel_data);
				strobe_count++;
				total_strobes++;
			end
		end
	end

	// Watchdog
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			fail_text("Timeout: the run did not finish within the cycle limit");
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////
	initial begin
		logic [7:0] read_value;
		logic [1:0] mode_seq [$];
		int lock_index;
		logic [7:0] stat_wr;
		logic seen_last_line;

		clock = 1'b0;
		reset = 1'b1;
		mem_enable = 1'b0;
		rd_n = 1'b1;
		wr_n = 1'b1;
		addr = 16'h0000;
		wdata = 8'h00;
		int_vblank_ack = 1'b0;
		int_lcdc_ack = 1'b0;
		checking = 1'b0;
		lcdc_val = 8'h00;
		scx_val = 8'h00;
		scy_val = 8'h00;
		bgp_val = 8'h00;
		total_strobes = 0;
		cycle_count = 0;
		void'($urandom(RAND_SEED));

		repeat (3) @(posedge clock);
		#0.5;
		reset = 1'b0;
		assert (!int_vblank_req && !int_lcdc_req)
			else fail_text("Interrupt request high after reset");

		// Register readback, LCD stays off
		cpu_write(ADDR_LCDC, 8'h5A);
		cpu_write(ADDR_SCY, 8'h3C);
		cpu_write(ADDR_SCX, 8'hA5);
		cpu_write(ADDR_LYC, 8'h33);
		cpu_write(ADDR_BGP, 8'h93);
		cpu_write(ADDR_STAT, 8'hFF);
		check_read(ADDR_LCDC, 8'h5A, "lcdc");
		check_read(ADDR_SCY, 8'h3C, "scy");
		check_read(ADDR_SCX, 8'hA5, "scx");
		check_read(ADDR_LYC, 8'h33, "lyc");
		check_read(ADDR_BGP, 8'h93, "bgp");
		// Writable bits, no coincidence, mode 0
		check_read(ADDR_STAT, {5'b11111, 1'b0, 2'd0}, "stat");
		// Raster parked on line 0 while the display is off
		check_read(ADDR_LY, 8'h00, "ly");
		cpu_write(ADDR_LYC, 8'h00);
		check_read(ADDR_STAT, {5'b11111, 1'b1, 2'd0}, "stat_coincidence");
		foreach (UNMAPPED[i]) begin
			check_read(UNMAPPED[i], 8'hFF, "unmapped");
		end
		cpu_write(ADDR_LCDC, 8'h00);
		cpu_write(ADDR_STAT, 8'h00);

		// Random VRAM image
		for (int i = 0; i < VRAM_BYTES; i++) begin
			vram_model[i] = 8'($urandom());
			cpu_write(VRAM_BASE + 16'(i), vram_model[i]);
		end
		for (int i = 0; i < VRAM_BYTES; i++) begin
			check_read(VRAM_BASE + 16'(i), vram_model[i], "vram_readback");
		end

		////////////////////////////////////////
		// Frame A, unsigned tiles, high map
		////////////////////////////////////////
		scx_val = 8'd13;
		scy_val = 8'd5;
		bgp_val = 8'h1B;
		lcdc_val = 8'h99;
		// LYC interrupt only
		stat_wr = 8'h40;
		cpu_write(ADDR_SCX, scx_val);
		cpu_write(ADDR_SCY, scy_val);
		cpu_write(ADDR_BGP, bgp_val);
		cpu_write(ADDR_LYC, 8'd20);
		cpu_write(ADDR_STAT, stat_wr);
		checking = 1'b1;
		cpu_write(ADDR_LCDC, lcdc_val);

		wait_line(1);
		check_read(ADDR_LY, 8'd1, "ly_running");
		// One STAT read per clock over the whole line
		while (line_count == 8'd1) begin
			cpu_read(ADDR_STAT, read_value);
			assert (read_value[7:2] == {stat_wr[7:3], 1'b0})
				else fail_value("stat_upper", {stat_wr[7:3], 1'b0}, read_value[7:2]);
			if (mode_seq.size() == 0 || mode_seq[$] != read_value[1:0]) begin
				mode_seq.push_back(read_value[1:0]);
			end
		end
		assert (mode_seq.size() == 3) else fail_value("mode_count", 3, mode_seq.size());
		for (int i = 0; i < 3; i++) begin
			assert (mode_seq[i] == MODE_ORDER[i])
				else fail_value("mode_order", MODE_ORDER[i], mode_seq[i]);
		end

		// Line 2 has just begun, 100 dots lands in mode 3
		repeat (100 * DOT_DIVIDE) step();
		cpu_read(ADDR_STAT, read_value);
		assert (read_value[1:0] == 2'd3) else fail_value("lock_mode", 3, read_value[1:0]);
		lock_index = 'h0A5C;
		cpu_write(VRAM_BASE + 16'(lock_index), ~vram_model[lock_index]);

		while (!int_lcdc_req) begin
			step();
		end
		assert (line_count == 8'd20) else fail_value("lyc_irq_line", 20, line_count);
		int_lcdc_ack = 1'b1;
		step();
		int_lcdc_ack = 1'b0;
		assert (!int_lcdc_req) else fail_value("lcdc_ack", 0, int_lcdc_req);

		while (!int_vblank_req) begin
			step();
		end
		assert (line_count == 8'd144) else fail_value("vblank_irq_line", 144, line_count);
		int_vblank_ack = 1'b1;
		step();
		int_vblank_ack = 1'b0;
		assert (!int_vblank_req) else fail_value("vblank_ack", 0, int_vblank_req);

		// Vertical blank, locked byte kept its old value
		check_read(VRAM_BASE + 16'(lock_index), vram_model[lock_index], "vram_lock");
		vram_model[1] = ~vram_model[1];
		cpu_write(VRAM_BASE + 16'd1, vram_model[1]);
		check_read(VRAM_BASE + 16'd1, vram_model[1], "vram_vblank_write");
		checking = 1'b0;
		cpu_write(ADDR_LCDC, 8'h00);

		////////////////////////////////////////
		// Frame B, signed tiles, low map
		////////////////////////////////////////
		bgp_val = 8'h2D;
		lcdc_val = 8'h81;
		cpu_write(ADDR_BGP, bgp_val);
		cpu_write(ADDR_STAT, 8'h00);
		checking = 1'b1;
		cpu_write(ADDR_LCDC, lcdc_val);
		seen_last_line = 1'b0;
		// Whole frame through the wrap with every STAT enable clear
		while (!(seen_last_line && line_count == 8'd0)) begin
			assert (!int_lcdc_req) else fail_value("lcdc_quiet", 0, int_lcdc_req);
			if (line_count == 8'd153) begin
				seen_last_line = 1'b1;
			end
			step();
		end
		// Let the monitor see the 153 to 0 step
		repeat (4) step();

		////////////////////////////////////////
		// Frame C, background off from line 0
		////////////////////////////////////////
		// Line 0 fetch starts at dot 80, well after this write
		lcdc_val = 8'h80;
		cpu_write(ADDR_LCDC, lcdc_val);
		wait_line(144);
		// Let the monitor count the last visible line
		repeat (4) step();
		checking = 1'b0;

		assert (total_strobes == 3 * 144 * 160)
			else fail_value("total_strobes", 3 * 144 * 160, total_strobes);
		$display("All checks passed");
		$finish;
	end

endmodule

// ==== src/lcd_top.sv ====
`timescale 1ns/1ps

module lcd_top
	import lcd_pkg::*;
#(
	parameter int DOT_DIVIDE = 8
) (
	input logic clock,
	input logic reset,
	// CPU bus
	input logic mem_enable,
	input logic rd_n,
	input logic wr_n,
	input logic [15:0] addr,
	input logic [7:0] wdata,
	output logic [7:0] rdata,
	// Interrupts
	input logic int_vblank_ack,
	input logic int_lcdc_ack,
	output logic int_vblank_req,
	output logic int_lcdc_req,
	// Panel side
	output logic hsync,
	output logic vsync,
	output logic [7:0] line_count,
	output logic [7:0] pixel_x,
	output logic [1:0] pixel_data,
	output logic pixel_we
);

	lcd_ctrl_if ctrl ();
	line_buf_if line_buf ();

	lcd_mode_t mode;
	logic [8:0] dot_count;
	logic [7:0] vram_rdata;
	logic [12:0] render_addr;
	logic [7:0] render_data;

	lcd_registers u_registers (
		.clock(clock),
		.reset(reset),
		.mem_enable(mem_enable),
		.rd_n(rd_n),
		.wr_n(wr_n),
		.addr(addr),
		.wdata(wdata),
		.vram_rdata(vram_rdata),
		.mode(mode),
		.line_count(line_count),
		.rdata(rdata),
		.ctrl(ctrl.source)
	);

	dot_timer #(
		.DOT_DIVIDE(DOT_DIVIDE)
	) u_dot_timer (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl.sink),
		.dot_count(dot_count),
		.line_count(line_count),
		.hsync(hsync),
		.vsync(vsync)
	);

	mode_control u_mode_control (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl.sink),
		.dot_count(dot_count),
		.line_count(line_count),
		.int_vblank_ack(int_vblank_ack),
		.int_lcdc_ack(int_lcdc_ack),
		.mode(mode),
		.int_vblank_req(int_vblank_req),
		.int_lcdc_req(int_lcdc_req)
	);

	video_ram u_video_ram (
		.clock(clock),
		.mem_enable(mem_enable),
		.wr_n(wr_n),
		.rd_n(rd_n),
		.addr(addr),
		.wdata(wdata),
		.mode(mode),
		.cpu_rdata(vram_rdata),
		.render_addr(render_addr),
		.render_data(render_data)
	);

	line_buffer u_line_buffer (
		.clock(clock),
		.line_buf(line_buf.store)
	);

	bg_renderer u_bg_renderer (
		.clock(clock),
		.reset(reset),
		.ctrl(ctrl.sink),
		.mode(mode),
		.line_count(line_count),
		.render_addr(render_addr),
		.render_data(render_data),
		.line_buf(line_buf.writer),
		.pixel_x(pixel_x),
		.pixel_data(pixel_data),
		.pixel_we(pixel_we)
	);

endmodule

// ==== src/bg_renderer.sv ====
`timescale 1ns/1ps

module bg_renderer
	import lcd_pkg::*;
(
	input logic clock,
	input logic reset,
	lcd_ctrl_if.sink ctrl,
	input lcd_mode_t mode,
	input logic [7:0] line_count,
	output logic [12:0] render_addr,
	input logic [7:0] render_data,
	line_buf_if.writer line_buf,
	output logic [7:0] pixel_x,
	output logic [1:0] pixel_data,
	output logic pixel_we
);

	render_state_t state;
	// Tile column within the fetch, 0 to 20
	logic [4:0] column;
	logic [7:0] out_index;
	logic [7:0] tile_num;
	logic [7:0] tile_low;
	// Background row for this line
	logic [7:0] tile_y;
	logic [4:0] map_col;
	logic [12:0] map_addr;
	logic [7:0] tile_num_src;
	logic [12:0] tile_base;
	logic fetching;

	////////////////////////////////////////
	// VRAM addressing
	////////////////////////////////////////
	assign tile_y = line_count + ctrl.scy;
	// Wraps around the 32 wide map
	assign map_col = ctrl.scx[7:3] + column;
	assign map_addr = (ctrl.map_sel ? MAP_BASE_HIGH : MAP_BASE_LOW) +
		{3'b000, tile_y[7:3], map_col};

	// Map byte arrives in RS_TILE_LOW, kept afterwards
	assign tile_num_src = (state == RS_TILE_LOW) ? render_data : tile_num;
	// 16 bytes per tile, signed numbers sit around 0x1000
	assign tile_base = ctrl.tile_data_sel ? {1'b0, tile_num_src, 4'b0000} :
		TILE_BASE_SIGNED + {tile_num_src[7], tile_num_src, 4'b0000};

	always_comb begin
		case (state)
			RS_TILE_LOW,
			RS_TILE_HIGH: begin
				// Two bytes per tile row, high plane second
				render_addr = tile_base + {9'd0, tile_y[2:0], state == RS_TILE_HIGH};
			end
			default: render_addr = map_addr;
		endcase
	end

	////////////////////////////////////////
	// Line buffer side
	////////////////////////////////////////
	assign line_buf.wr_en = (state == RS_ROW_WRITE);
	// Fine scroll shifts the row left, may go negative
	assign line_buf.wr_base = $signed({1'b0, column, 3'b000}) - $signed({6'd0, ctrl.scx[2:0]});
	assign line_buf.rd_index = out_index;

	// Bit 7 is the leftmost pixel
	always_comb begin
		for (int k = 0; k < 8; k++) begin
			line_buf.wr_row[k] = ctrl.bg_enable ? {render_data[7-k], tile_low[7-k]} : 2'b00;
		end
	end

	assign fetching = (state == RS_MAP) || (state == RS_TILE_LOW) ||
		(state == RS_TILE_HIGH) || (state == RS_ROW_WRITE);

	////////////////////////////////////////
	// FSM
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset || !ctrl.lcd_on) begin
			state <= RS_IDLE;
			pixel_we <= 1'b0;
		end else begin
			pixel_we <= 1'b0;
			case (state)
				RS_IDLE: begin
					if (mode == MODE_TRANSFER) begin
						state <= RS_MAP;
					end
				end
				RS_MAP: state <= RS_TILE_LOW;
				RS_TILE_LOW: state <= RS_TILE_HIGH;
				RS_TILE_HIGH: state <= RS_ROW_WRITE;
				RS_ROW_WRITE: begin
					if (column == 5'(TILE_COLUMNS - 1)) begin
						state <= RS_OUT_WAIT;
					end else begin
						state <= RS_MAP;
					end
				end
				// Stream only in H-blank
				RS_OUT_WAIT: begin
					if (mode == MODE_HBLANK) begin
						state <= RS_OUT_READ;
					end
				end
				RS_OUT_READ: state <= RS_OUT_EMIT;
				RS_OUT_EMIT: begin
					pixel_we <= 1'b1;
					if (out_index == 8'(SCREEN_WIDTH - 1)) begin
						state <= RS_IDLE;
					end else begin
						state <= RS_OUT_READ;
					end
				end
				default: state <= RS_IDLE;
			endcase
			// Failsafe, mode 3 over before the fetch finished
			if (fetching && (mode != MODE_TRANSFER)) begin
				state <= RS_OUT_WAIT;
			end
		end
	end

	// Counters and fetched bytes
	always_ff @(posedge clock) begin
		case (state)
			RS_IDLE: column <= 5'd0;
			RS_TILE_LOW: tile_num <= render_data;
			RS_TILE_HIGH: tile_low <= render_data;
			RS_ROW_WRITE: column <= column + 5'd1;
			RS_OUT_WAIT: out_index <= 8'd0;
			RS_OUT_EMIT: begin
				pixel_x <= out_index;
				// BGP field picked by the colour index
				pixel_data <= ctrl.bgp[{line_buf.rd_pixel, 1'b0} +: 2];
				out_index <= out_index + 8'd1;
			end
			default: ;
		endcase
	end

	assert property (@(posedge clock) disable iff (reset)
		pixel_we |-> (pixel_x < 8'(SCREEN_WIDTH)))
		else $error("pixel strobe past the line end");

endmodule

// ==== src/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer
	import lcd_pkg::*;
(
	input logic clock,
	line_buf_if.store line_buf
);

	// One colour index per screen column
	logic [1:0] pixels [0:SCREEN_WIDTH-1];
	logic signed [9:0] slot_pos [8];
	logic [7:0] slot_ok;

	// Screen column of each index in the row
	for (genvar i = 0; i < 8; i++) begin : g_slot
		assign slot_pos[i] = line_buf.wr_base + i;
		// Partial tiles at either edge
		assign slot_ok[i] = (slot_pos[i] >= 0) && (slot_pos[i] < SCREEN_WIDTH);
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < 8; i++) begin
			if (line_buf.wr_en && slot_ok[i]) begin
				pixels[slot_pos[i][7:0]] <= line_buf.wr_row[i];
			end
		end
		line_buf.rd_pixel <= pixels[line_buf.rd_index];
	end

endmodule

// ==== src/video_ram.sv ====
`timescale 1ns/1ps

module video_ram
	import lcd_pkg::*;
(
	input logic clock,
	input logic mem_enable,
	input logic wr_n,
	input logic rd_n,
	input logic [15:0] addr,
	input logic [7:0] wdata,
	input lcd_mode_t mode,
	output logic [7:0] cpu_rdata,
	input logic [12:0] render_addr,
	output logic [7:0] render_data
);

	logic [7:0] mem [0:8191];
	logic in_region;
	logic cpu_write_req;
	logic cpu_write;
	logic cpu_read;
	// Region is 8 KiB aligned, low bits are the offset
	logic [12:0] cpu_index;

	assign in_region = (addr >= VRAM_BASE) && (addr <= VRAM_END);
	assign cpu_index = addr[12:0];
	assign cpu_write_req = mem_enable && !wr_n && rd_n && in_region;
	// Locked while the renderer owns the bus
	assign cpu_write = cpu_write_req && (mode != MODE_TRANSFER);
	assign cpu_read = mem_enable && !rd_n && in_region;

	always_ff @(posedge clock) begin
		if (cpu_write) begin
			mem[cpu_index] <= wdata;
		end
		// Holds the last CPU read
		if (cpu_read) begin
			cpu_rdata <= mem[cpu_index];
		end
		render_data <= mem[render_addr];
	end

	// A CPU write in mode 3 leaves the byte untouched
	assert property (@(posedge clock)
		(cpu_write_req && (mode == MODE_TRANSFER)) |=>
		(mem[$past(cpu_index)] === $past(mem[cpu_index])))
		else $error("VRAM written during pixel transfer");

endmodule

// ==== src/mode_control.sv ====
`timescale 1ns/1ps

module mode_control
	import lcd_pkg::*;
(
	input logic clock,
	input logic reset,
	lcd_ctrl_if.sink ctrl,
	input logic [8:0] dot_count,
	input logic [7:0] line_count,
	input logic int_vblank_ack,
	input logic int_lcdc_ack,
	output lcd_mode_t mode,
	output logic int_vblank_req,
	output logic int_lcdc_req
);

	lcd_mode_t next_mode;
	logic mode_change;
	logic entry_enabled;
	logic lyc_now;
	logic lyc_seen;

	// Mode from the raster position
	always_comb begin
		if (!ctrl.lcd_on) begin
			next_mode = MODE_HBLANK;
		end else if (line_count >= 8'(VISIBLE_LINES)) begin
			next_mode = MODE_VBLANK;
		end else if (dot_count < 9'(OAM_DOTS)) begin
			next_mode = MODE_OAM;
		end else if (dot_count < 9'(OAM_DOTS + TRANSFER_DOTS)) begin
			next_mode = MODE_TRANSFER;
		end else begin
			next_mode = MODE_HBLANK;
		end
	end

	assign mode_change = ctrl.lcd_on && (next_mode != mode);

	// STAT enable for the mode being entered, mode 3 has none
	always_comb begin
		case (next_mode)
			MODE_HBLANK: entry_enabled = ctrl.stat_irq_enable[0];
			MODE_VBLANK: entry_enabled = ctrl.stat_irq_enable[1];
			MODE_OAM: entry_enabled = ctrl.stat_irq_enable[2];
			default: entry_enabled = 1'b0;
		endcase
	end

	// LYC match at the first dot of the line
	assign lyc_now = ctrl.lcd_on && (dot_count == 9'd0) && (line_count == ctrl.lyc);

	always_ff @(posedge clock) begin
		if (reset) begin
			mode <= MODE_HBLANK;
			lyc_seen <= 1'b0;
			int_vblank_req <= 1'b0;
			int_lcdc_req <= 1'b0;
		end else begin
			mode <= next_mode;
			// Dot 0 lasts several clocks, fire once
			lyc_seen <= lyc_now;

			if (mode_change && (next_mode == MODE_VBLANK)) begin
				int_vblank_req <= 1'b1;
			end else if (int_vblank_ack) begin
				int_vblank_req <= 1'b0;
			end

			if ((mode_change && entry_enabled) ||
				(lyc_now && !lyc_seen && ctrl.stat_irq_enable[3])) begin
				int_lcdc_req <= 1'b1;
			end else if (int_lcdc_ack) begin
				int_lcdc_req <= 1'b0;
			end
		end
	end

endmodule

// ==== src/dot_timer.sv ====
`timescale 1ns/1ps

module dot_timer
	import lcd_pkg::*;
#(
	parameter int DOT_DIVIDE = 8
) (
	input logic clock,
	input logic reset,
	lcd_ctrl_if.sink ctrl,
	output logic [8:0] dot_count,
	output logic [7:0] line_count,
	output logic hsync,
	output logic vsync
);

	localparam int DIV_WIDTH = (DOT_DIVIDE > 1) ? $clog2(DOT_DIVIDE) : 1;

	logic [DIV_WIDTH-1:0] div_count;
	logic dot_tick;

	// One dot every DOT_DIVIDE clocks
	assign dot_tick = (div_count == DIV_WIDTH'(DOT_DIVIDE - 1));

	always_ff @(posedge clock) begin
		// Display off parks the raster at the top left
		if (reset || !ctrl.lcd_on) begin
			div_count <= '0;
			dot_count <= 9'd0;
			line_count <= 8'd0;
		end else begin
			div_count <= dot_tick ? '0 : div_count + 1'b1;
			if (dot_tick) begin
				if (dot_count == 9'(DOTS_PER_LINE - 1)) begin
					dot_count <= 9'd0;
					// Line wraps after the last vblank line
					if (line_count == 8'(LINES_PER_FRAME - 1)) begin
						line_count <= 8'd0;
					end else begin
						line_count <= line_count + 8'd1;
					end
				end else begin
					dot_count <= dot_count + 9'd1;
				end
			end
		end
	end

	// Sync after the visible part of the line
	assign hsync = dot_count > 9'(OAM_DOTS + TRANSFER_DOTS + SCREEN_WIDTH);
	assign vsync = line_count > 8'(VISIBLE_LINES);

	assert property (@(posedge clock) disable iff (reset)
		(dot_count < 9'(DOTS_PER_LINE)) && (line_count < 8'(LINES_PER_FRAME)))
		else $error("raster counter past its wrap value");

endmodule

// ==== src/lcd_registers.sv ====
`timescale 1ns/1ps

module lcd_registers
	import lcd_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic mem_enable,
	input logic rd_n,
	input logic wr_n,
	input logic [15:0] addr,
	input logic [7:0] wdata,
	input logic [7:0] vram_rdata,
	input lcd_mode_t mode,
	input logic [7:0] line_count,
	output logic [7:0] rdata,
	lcd_ctrl_if.source ctrl
);

	logic [7:0] lcdc;
	logic [7:0] scy;
	logic [7:0] scx;
	logic [7:0] lyc;
	logic [7:0] bgp;
	// STAT bits 7 to 3, the only writable part
	logic [4:0] stat_w;
	logic [7:0] stat;
	logic cpu_read;
	logic cpu_write;
	logic vram_hit;
	logic vram_sel;
	logic [7:0] reg_rdata;

	assign vram_hit = (addr >= VRAM_BASE) && (addr <= VRAM_END);
	assign cpu_read = mem_enable && !rd_n;
	// Read strobe wins over write
	assign cpu_write = mem_enable && !wr_n && rd_n;

	// Coincidence flag and mode are live
	assign stat = {stat_w, line_count == lyc, mode};

	////////////////////////////////////////
	// Register writes
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			lcdc <= 8'h00;
			stat_w <= 5'd0;
			scy <= 8'h00;
			scx <= 8'h00;
			lyc <= 8'h00;
			bgp <= 8'hFC;
		end else if (cpu_write) begin
			case (addr)
				ADDR_LCDC: lcdc <= wdata;
				ADDR_STAT: stat_w <= wdata[7:3];
				ADDR_SCY: scy <= wdata;
				ADDR_SCX: scx <= wdata;
				ADDR_LYC: lyc <= wdata;
				ADDR_BGP: bgp <= wdata;
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// Read mux, captured on the read strobe
	////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			vram_sel <= 1'b0;
			reg_rdata <= 8'hFF;
		end else if (cpu_read) begin
			vram_sel <= vram_hit;
			case (addr)
				ADDR_LCDC: reg_rdata <= lcdc;
				ADDR_STAT: reg_rdata <= stat;
				ADDR_SCY: reg_rdata <= scy;
				ADDR_SCX: reg_rdata <= scx;
				ADDR_LY: reg_rdata <= line_count;
				ADDR_LYC: reg_rdata <= lyc;
				ADDR_BGP: reg_rdata <= bgp;
				// Unmapped reads float high
				default: reg_rdata <= 8'hFF;
			endcase
		end
	end

	// VRAM byte is registered inside the RAM and held until its next read
	assign rdata = vram_sel ? vram_rdata : reg_rdata;

	// LCDC fields
	assign ctrl.lcd_on = lcdc[7];
	assign ctrl.tile_data_sel = lcdc[4];
	assign ctrl.map_sel = lcdc[3];
	assign ctrl.bg_enable = lcdc[0];
	assign ctrl.scx = scx;
	assign ctrl.scy = scy;
	assign ctrl.bgp = bgp;
	assign ctrl.lyc = lyc;
	assign ctrl.stat_irq_enable = stat_w[3:0];

	// Bus master never drives both strobes
	assert property (@(posedge clock) disable iff (reset)
		mem_enable |-> !(!rd_n && !wr_n))
		else $error("read and write strobed together");

endmodule

// ==== src/lcd_ctrl_if.sv ====
`timescale 1ns/1ps

// Register settings fanned out from the register file
interface lcd_ctrl_if;
	// LCDC bit 7
	logic lcd_on;
	// LCDC bit 0
	logic bg_enable;
	// LCDC bit 4, unsigned tile data at 0x8000
	logic tile_data_sel;
	// LCDC bit 3, tile map at 0x9C00
	logic map_sel;
	logic [7:0] scx;
	logic [7:0] scy;
	logic [7:0] bgp;
	logic [7:0] lyc;
	// STAT bits 6 to 3: LYC, OAM, vblank, hblank
	logic [3:0] stat_irq_enable;

	modport source (
		output lcd_on, bg_enable, tile_data_sel, map_sel,
		output scx, scy, bgp, lyc, stat_irq_enable
	);

	modport sink (
		input lcd_on, bg_enable, tile_data_sel, map_sel,
		input scx, scy, bgp, lyc, stat_irq_enable
	);
endinterface

// Renderer to line buffer
interface line_buf_if;
	logic wr_en;
	// Screen column of wr_row[0], may be negative
	logic signed [8:0] wr_base;
	// Eight colour indices, element 0 leftmost
	logic [7:0][1:0] wr_row;
	logic [7:0] rd_index;
	// One clock after rd_index
	logic [1:0] rd_pixel;

	modport writer (
		output wr_en, wr_base, wr_row, rd_index,
		input rd_pixel
	);

	modport store (
		input wr_en, wr_base, wr_row, rd_index,
		output rd_pixel
	);
endinterface

// ==== src/lcd_pkg.sv ====
package lcd_pkg;

	////////////////////////////////////////
	// Raster timing, in dots and lines
	////////////////////////////////////////
	localparam int DOTS_PER_LINE = 456;
	localparam int LINES_PER_FRAME = 154;
	localparam int VISIBLE_LINES = 144;
	localparam int SCREEN_WIDTH = 160;
	// Mode 2 and mode 3 lengths
	localparam int OAM_DOTS = 80;
	localparam int TRANSFER_DOTS = 172;

	// Tiles fetched per line, one more than the screen for fine scroll
	localparam int TILE_COLUMNS = 21;
	// VRAM offsets of the two tile maps
	localparam logic [12:0] MAP_BASE_LOW = 13'h1800;
	localparam logic [12:0] MAP_BASE_HIGH = 13'h1C00;
	// Tile 0 for signed tile numbers
	localparam logic [12:0] TILE_BASE_SIGNED = 13'h1000;

	////////////////////////////////////////
	// CPU bus map
	////////////////////////////////////////
	localparam logic [15:0] ADDR_LCDC = 16'hFF40;
	localparam logic [15:0] ADDR_STAT = 16'hFF41;
	localparam logic [15:0] ADDR_SCY = 16'hFF42;
	localparam logic [15:0] ADDR_SCX = 16'hFF43;
	localparam logic [15:0] ADDR_LY = 16'hFF44;
	localparam logic [15:0] ADDR_LYC = 16'hFF45;
	localparam logic [15:0] ADDR_BGP = 16'hFF47;
	localparam logic [15:0] VRAM_BASE = 16'h8000;
	localparam logic [15:0] VRAM_END = 16'h9FFF;

	// STAT mode field encoding
	typedef enum logic [1:0] {
		MODE_HBLANK = 2'd0,
		MODE_VBLANK = 2'd1,
		MODE_OAM = 2'd2,
		MODE_TRANSFER = 2'd3
	} lcd_mode_t;

	// Background fetch and pixel output
	typedef enum logic [2:0] {
		RS_IDLE,
		RS_MAP,
		RS_TILE_LOW,
		RS_TILE_HIGH,
		RS_ROW_WRITE,
		RS_OUT_WAIT,
		RS_OUT_READ,
		RS_OUT_EMIT
	} render_state_t;

endpackage
